/* include/accum_config.svh */
`ifndef ACCUM_CONFIG_SVH
`define ACCUM_CONFIG_SVH

// binary32 field widths
`define FP_EXP_W 8
`define FP_MAN_W 23
`define FP_BIAS 127

// Exact sum of any binary32 group
// 24-bit significand shifted by up to 253, plus carry headroom and sign
`define ACC_W 279

// Wide enough to hold ACC_W itself
`define LZC_W 9

`endif

/* verilog/fp_types_pkg.sv */
`default_nettype none

`include "accum_config.svh"

package fp_types_pkg;

   // Raw binary32 word as it travels on the stream
   typedef logic [31:0] fp32_t;

   typedef logic [`FP_EXP_W-1:0] fp_exp_t;
   typedef logic [`FP_MAN_W-1:0] fp_man_t;

   // Stored mantissa with the hidden bit in front
   typedef logic [`FP_MAN_W:0] fp_sig_t;

   // Field view of a binary32 word
   typedef struct packed {
      logic    sign;
      fp_exp_t exp;
      fp_man_t man;
   } fp_fields_t;

   localparam fp_exp_t FP_EXP_MAX = '1;

endpackage

`default_nettype wire

/* verilog/accum_pkg.sv */
`default_nettype none

`include "accum_config.svh"

package accum_pkg;

   import fp_types_pkg::*;

   // Fixed point, one LSB is 2^-149
   typedef logic signed [`ACC_W-1:0] acc_t;

   // Magnitude of a sum, same scale
   typedef logic [`ACC_W-1:0] acc_mag_t;

   typedef logic [`LZC_W-1:0] lzc_t;

   // Input stream beat
   typedef struct packed {
      fp32_t value;
      logic  last;
   } in_beat_t;

   // Decoded term on its way to the accumulator
   typedef struct packed {
      acc_t value;
      logic last;
   } fix_beat_t;

   // Finished group total
   typedef struct packed {
      acc_t value;
   } sum_beat_t;

   // Accumulator group control
   typedef enum logic {
      ACC_START,
      ACC_RUN
   } acc_state_e;

endpackage

`default_nettype wire

/* verilog/leading_zero_count.sv */
`timescale 1ns/1ps
`default_nettype none

module leading_zero_count #(
   parameter int WIDTH   = 279,
   parameter int COUNT_W = 9
) (
   input  wire  [WIDTH-1:0]   vec,
   output logic [COUNT_W-1:0] count
);

   // Scan upward, the highest set bit wins
   always_comb begin
      count = COUNT_W'(WIDTH);
      for (int i = 0; i < WIDTH; i++) begin
         if (vec[i]) begin
            count = COUNT_W'(WIDTH - 1 - i);
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/float_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "accum_config.svh"

module float_decode
   import fp_types_pkg::*, accum_pkg::*;
(
   input  wire       clk,
   input  wire       rst,
   input  in_beat_t  in_beat,
   input  wire       in_valid,
   output logic      in_ready,
   output fix_beat_t fix_beat,
   output logic      fix_valid,
   input  wire       fix_ready
);

   fp_fields_t fields;
   fp_sig_t    sig;
   fp_exp_t    shift;
   acc_t       mag;
   acc_t       fixed;
   logic       take;

   assign fields = fp_fields_t'(in_beat.value);

   // Hidden bit only for normal numbers
   assign sig = {(fields.exp != '0), fields.man};

   // Subnormals share the scale of exponent 1
   assign shift = (fields.exp == '0) ? '0 : fields.exp - 1'b1;

   assign mag = acc_t'(sig) << shift;
   assign fixed = fields.sign ? -mag : mag;

   assign in_ready = !fix_valid || fix_ready;
   assign take = in_valid && in_ready;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         fix_valid <= 1'b0;
      end else if (take) begin
         fix_valid <= 1'b1;
      end else if (fix_ready) begin
         fix_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         fix_beat.value <= fixed;
         fix_beat.last <= in_beat.last;
      end
   end

   // Inf and NaN have no fixed-point form
   a_no_inf_nan: assert property (
      @(posedge clk) disable iff (rst)
      take |-> (fields.exp != FP_EXP_MAX)
   ) else $error("float_decode: infinity or NaN word accepted");

endmodule

`default_nettype wire

/* verilog/fixed_accumulate.sv */
`timescale 1ns/1ps
`default_nettype none

`include "accum_config.svh"

module fixed_accumulate
   import accum_pkg::*;
(
   input  wire       clk,
   input  wire       rst,
   input  fix_beat_t fix_beat,
   input  wire       fix_valid,
   output logic      fix_ready,
   output sum_beat_t sum_beat,
   output logic      sum_valid,
   input  wire       sum_ready
);

   acc_state_e state;
   acc_t       sum_q;
   acc_t       add_sum;
   acc_t       next_sum;
   logic       take;
   logic       add_ovf;

   // Stall only while a finished total waits downstream
   assign fix_ready = !sum_valid || sum_ready;
   assign take = fix_valid && fix_ready;

   assign add_sum = sum_q + fix_beat.value;

   // First beat of a group replaces the old total
   assign next_sum = (state == ACC_START) ? fix_beat.value : add_sum;

   // Same-sign operands giving an opposite-sign result
   assign add_ovf = (sum_q[`ACC_W-1] == fix_beat.value[`ACC_W-1]) &&
                    (add_sum[`ACC_W-1] != sum_q[`ACC_W-1]);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= ACC_START;
      end else if (take) begin
         state <= fix_beat.last ? ACC_START : ACC_RUN;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         sum_q <= next_sum;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         sum_valid <= 1'b0;
      end else if (take && fix_beat.last) begin
         sum_valid <= 1'b1;
      end else if (sum_ready) begin
         sum_valid <= 1'b0;
      end
   end

   // Total including the closing beat
   always_ff @(posedge clk) begin
      if (take && fix_beat.last) begin
         sum_beat.value <= next_sum;
      end
   end

   a_no_wrap: assert property (
      @(posedge clk) disable iff (rst)
      (take && state == ACC_RUN) |-> !add_ovf
   ) else $error("fixed_accumulate: running sum wrapped past the sign bit");

endmodule

`default_nettype wire

/* verilog/float_result.sv */
`timescale 1ns/1ps
`default_nettype none

`include "accum_config.svh"

module float_result
   import fp_types_pkg::*, accum_pkg::*;
(
   input  wire       clk,
   input  wire       rst,
   input  sum_beat_t sum_beat,
   input  wire       sum_valid,
   output logic      sum_ready,
   output fp32_t     out_value,
   output logic      out_valid,
   input  wire       out_ready
);

   // Biased exponent is p minus this
   localparam int EXP_OFFSET = `FP_MAN_W - 1;
   localparam int EXP_NORM_MAX = (1 << `FP_EXP_W) - 2;
   localparam lzc_t TOP_POS = lzc_t'(`ACC_W - 1);

   logic       in_sign;
   acc_mag_t   in_mag;
   lzc_t       in_lzc;
   logic       sum_take;

   logic       s1_valid;
   logic       s1_sign;
   acc_mag_t   s1_mag;
   lzc_t       s1_lzc;
   logic       s2_ready;
   logic       s2_take;

   lzc_t       p;
   acc_mag_t   norm;
   fp_fields_t res;

   assign in_sign = sum_beat.value[`ACC_W-1];
   assign in_mag = in_sign ? acc_mag_t'(-sum_beat.value) : acc_mag_t'(sum_beat.value);

   leading_zero_count #(
      .WIDTH   (`ACC_W),
      .COUNT_W (`LZC_W)
   ) u_lzc (
      .vec   (in_mag),
      .count (in_lzc)
   );

   assign s2_ready = !out_valid || out_ready;
   assign sum_ready = !s1_valid || s2_ready;
   assign sum_take = sum_valid && sum_ready;
   assign s2_take = s1_valid && s2_ready;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         s1_valid <= 1'b0;
      end else if (sum_take) begin
         s1_valid <= 1'b1;
      end else if (s2_ready) begin
         s1_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (sum_take) begin
         s1_sign <= in_sign;
         s1_mag <= in_mag;
         s1_lzc <= in_lzc;
      end
   end

   assign p = TOP_POS - s1_lzc;

   // Top bit moved to the MSB, mantissa sits right below it
   assign norm = s1_mag << s1_lzc;

   always_comb begin
      res.sign = s1_sign;
      res.exp = fp_exp_t'(p - lzc_t'(EXP_OFFSET));
      res.man = norm[`ACC_W-2 -: `FP_MAN_W];
      if (s1_lzc == lzc_t'(`ACC_W)) begin
         res = '0;
      end else if (p < lzc_t'(`FP_MAN_W)) begin
         res.exp = '0;
         res.man = s1_mag[`FP_MAN_W-1:0];
      end else if ((p - lzc_t'(EXP_OFFSET)) > lzc_t'(EXP_NORM_MAX)) begin
         // Saturate to signed infinity
         res.exp = FP_EXP_MAX;
         res.man = '0;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else if (s2_take) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (s2_take) begin
         out_value <= fp32_t'(res);
      end
   end

endmodule

`default_nettype wire

/* verilog/float_accum_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "accum_config.svh"

module float_accum_top
   import fp_types_pkg::*, accum_pkg::*;
(
   input  wire      clk,
   input  wire      rst,
   input  in_beat_t in_beat,
   input  wire      in_valid,
   output logic     in_ready,
   output fp32_t    out_value,
   output logic     out_valid,
   input  wire      out_ready
);

   fix_beat_t fix_beat;
   logic      fix_valid;
   logic      fix_ready;

   sum_beat_t sum_beat;
   logic      sum_valid;
   logic      sum_ready;

   float_decode u_decode (
      .clk       (clk),
      .rst       (rst),
      .in_beat   (in_beat),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .fix_beat  (fix_beat),
      .fix_valid (fix_valid),
      .fix_ready (fix_ready)
   );

   fixed_accumulate u_accumulate (
      .clk       (clk),
      .rst       (rst),
      .fix_beat  (fix_beat),
      .fix_valid (fix_valid),
      .fix_ready (fix_ready),
      .sum_beat  (sum_beat),
      .sum_valid (sum_valid),
      .sum_ready (sum_ready)
   );

   float_result u_result (
      .clk       (clk),
      .rst       (rst),
      .sum_beat  (sum_beat),
      .sum_valid (sum_valid),
      .sum_ready (sum_ready),
      .out_value (out_value),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

endmodule

`default_nettype wire

/* verif/float_accum_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module float_accum_tb
   import fp_types_pkg::*, accum_pkg::*;
();

   localparam int NUM_TESTS    = 13;
   localparam int NUM_WORDS    = 22;
   localparam int WAIT_LIMIT   = 200;
   localparam int DRAIN_CYCLES = 60;

   logic     clk;
   logic     rst;
   in_beat_t in_beat;
   logic     in_valid;
   logic     in_ready;
   fp32_t    out_value;
   logic     out_valid;
   logic     out_ready;

   logic [15:0] lfsr_state = 16'd26;
   int          result_count;

   // One row per group, words are stored back to back
   string test_name [NUM_TESTS] = '{
      "one", "neg_small", "min_subnormal", "max_finite", "neg_zero",
      "add_exact", "big_cancel", "trunc_pos", "trunc_neg", "cancel_zero",
      "overflow_pos", "overflow_neg", "subnormal_carry"
   };

   int word_count [NUM_TESTS] = '{1, 1, 1, 1, 1, 2, 3, 2, 2, 2, 2, 2, 2};

   fp32_t expected [NUM_TESTS] = '{
      32'h3F800000, 32'hC0200000, 32'h00000001, 32'h7F7FFFFF, 32'h00000000,
      32'h40600000, 32'h3F800000, 32'h3F800000, 32'hBF800000, 32'h00000000,
      32'h7F800000, 32'hFF800000, 32'h00800000
   };

   // Two copies of the largest finite value already leave the binary32 range
   fp32_t words [NUM_WORDS] = '{
      32'h3F800000,
      32'hC0200000,
      32'h00000001,
      32'h7F7FFFFF,
      32'h80000000,
      32'h3F800000, 32'h40200000,
      32'h7149F2CA, 32'hF149F2CA, 32'h3F800000,
      32'h3F800000, 32'h30800000,
      32'hBF800000, 32'hB0800000,
      32'h40490FDB, 32'hC0490FDB,
      32'h7F7FFFFF, 32'h7F7FFFFF,
      32'hFF7FFFFF, 32'hFF7FFFFF,
      32'h00400000, 32'h00400000
   };

   float_accum_top uut (
      .clk       (clk),
      .rst       (rst),
      .in_beat   (in_beat),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_value (out_value),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic next_random_bit();
      logic bit_out;
      bit_out = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (bit_out) begin
         lfsr_state = lfsr_state ^ 16'hB400;
      end
      return bit_out;
   endfunction

   task automatic stop_run(input string reason);
      $display("%s", reason);
      $display("Checks failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_float(input string name, input fp32_t exp_value, input fp32_t act_value);
      if (act_value !== exp_value) begin
         stop_run($sformatf("Mismatch %s: expected %08h, actual %08h",
                            name, exp_value, act_value));
      end
   endtask

   task automatic check_count(input string name, input int exp_value, input int act_value);
      if (act_value != exp_value) begin
         stop_run($sformatf("Mismatch %s: expected %0d, actual %0d",
                            name, exp_value, act_value));
      end
   endtask

   task automatic send_word(input fp32_t value, input logic last);
      int   waited;
      logic accepted;
      @(negedge clk);
      in_beat.value = value;
      in_beat.last = last;
      in_valid = 1'b1;
      waited = 0;
      accepted = 1'b0;
      while (!accepted) begin
         @(posedge clk);
         accepted = in_ready;
         waited++;
         if (!accepted && waited >= WAIT_LIMIT) begin
            stop_run("Timeout: the DUT did not accept an input word");
         end
      end
      // Idle cycle before the next word, chosen at the rising edge
      if (next_random_bit()) begin
         @(negedge clk);
         in_valid = 1'b0;
      end
   endtask

   task automatic drive_stream();
      int w;
      w = 0;
      for (int t = 0; t < NUM_TESTS; t++) begin
         for (int k = 0; k < word_count[t]; k++) begin
            send_word(words[w], k == word_count[t] - 1);
            w++;
         end
      end
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   task automatic collect_results();
      int   waited;
      logic got;
      for (int r = 0; r < NUM_TESTS; r++) begin
         waited = 0;
         got = 1'b0;
         while (!got) begin
            @(posedge clk);
            got = out_valid && out_ready;
            waited++;
            if (!got && waited >= WAIT_LIMIT) begin
               stop_run($sformatf("Timeout: no result arrived for test %s", test_name[r]));
            end
         end
         check_float(test_name[r], expected[r], out_value);
         result_count++;
      end
   endtask

   // Any extra result after the last group counts against the total
   task automatic drain_outputs();
      for (int c = 0; c < DRAIN_CYCLES; c++) begin
         @(posedge clk);
         if (out_valid && out_ready) begin
            result_count++;
         end
      end
   endtask

   // Random back-pressure, low about a quarter of the time
   initial begin
      logic b0;
      logic b1;
      forever begin
         @(negedge clk);
         b0 = next_random_bit();
         b1 = next_random_bit();
         out_ready = !(b0 && b1);
      end
   end

   initial begin
      rst = 1'b1;
      in_valid = 1'b0;
      in_beat = '0;
      out_ready = 1'b0;
      result_count = 0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      fork
         drive_stream();
         collect_results();
      join
      drain_outputs();
      check_count("result_count", NUM_TESTS, result_count);
      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

/* float_accum.f */
+incdir+include
verilog/fp_types_pkg.sv
verilog/accum_pkg.sv
verilog/leading_zero_count.sv
verilog/float_decode.sv
verilog/fixed_accumulate.sv
verilog/float_result.sv
verilog/float_accum_top.sv
verif/float_accum_tb.sv

/* Bender.yml */
package:
  name: float_accum

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/fp_types_pkg.sv
      - verilog/accum_pkg.sv
      - verilog/leading_zero_count.sv
      - verilog/float_decode.sv
      - verilog/fixed_accumulate.sv
      - verilog/float_result.sv
      - verilog/float_accum_top.sv
  - target: test
    files:
      - verif/float_accum_tb.sv
